/* hdl/mmu_pkg.sv */
// fixed 4 KB pages only; config word layout fills all 84 bits, c0/c1 are carried but not stored
package mmu_pkg;

    // decoded segment of a virtual address
    typedef enum logic [1:0] {
        SEG_KUSEG,   // 0x0000_0000 .. 0x7fff_ffff, mapped
        SEG_KSEG0,   // 0x8000_0000 .. 0x9fff_ffff, direct, cached
        SEG_KSEG1,   // 0xa000_0000 .. 0xbfff_ffff, direct, uncached
        SEG_KSEG23   // 0xc000_0000 and up, mapped
    } seg_e;

    localparam int VPN2_W      = 19;  // va[31:13]
    localparam int ASID_W      = 8;
    localparam int PFN_W       = 20;  // pa[31:12]
    localparam int OFFSET_W    = 12;  // 4 KB page
    localparam int CFG_INDEX_W = 6;   // enough for 64 entries

    // configuration word from the system coprocessor
    localparam int TLB_CFG_W   = 84;

    // field positions, top down
    localparam int CFG_INDEX_HI = 83;
    localparam int CFG_INDEX_LO = 78;
    localparam int CFG_VPN2_HI  = 77;
    localparam int CFG_VPN2_LO  = 59;
    localparam int CFG_ASID_HI  = 58;
    localparam int CFG_ASID_LO  = 51;
    localparam int CFG_G        = 50;  // global, ignores asid
    localparam int CFG_PFN0_HI  = 49;
    localparam int CFG_PFN0_LO  = 30;
    localparam int CFG_C0_HI    = 29;  // cache attr, even page
    localparam int CFG_C0_LO    = 27;
    localparam int CFG_D0       = 26;
    localparam int CFG_V0       = 25;
    localparam int CFG_PFN1_HI  = 24;
    localparam int CFG_PFN1_LO  = 5;
    localparam int CFG_C1_HI    = 4;   // cache attr, odd page
    localparam int CFG_C1_LO    = 2;
    localparam int CFG_D1       = 1;
    localparam int CFG_V1       = 0;

    // tlbp result, set when nothing matched
    localparam int PROBE_MISS_BIT = 31;

    // one stored entry, an even/odd page pair
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;     // match any asid
        logic [PFN_W-1:0]  pfn0;  // even page
        logic              d0;    // writable
        logic              v0;
        logic [PFN_W-1:0]  pfn1;  // odd page
        logic              d1;
        logic              v1;
        logic              vld;   // slot written since reset
    } tlb_entry_t;

endpackage

/* hdl/mem_map.sv */
// purely combinational segment decode; mapped segments return 0 here and rely on the tlb path
`timescale 1ns/1ns

module mem_map import mmu_pkg::*; (
    input  logic [31:0] addr_i,       // virtual address
    input  logic        enable_i,     // channel active
    input  logic        user_mode_i,
    output logic [31:0] addr_o,       // direct physical, kseg0/kseg1 only
    output logic        using_tlb_o,  // kuseg or kseg2/3
    output logic        illegal_o,    // kernel address from user mode
    output logic        uncached_o    // kseg1
);

    seg_e seg;

    // top three bits pick the segment
    always_comb begin
        casez (addr_i[31:29])
            3'b0??:  seg = SEG_KUSEG;
            3'b100:  seg = SEG_KSEG0;
            3'b101:  seg = SEG_KSEG1;
            default: seg = SEG_KSEG23;  // 110, 111
        endcase
    end

    always_comb begin
        addr_o      = '0;
        using_tlb_o = 1'b0;
        illegal_o   = 1'b0;
        uncached_o  = 1'b0;

        if (enable_i) begin
            case (seg)
                SEG_KUSEG: begin
                    using_tlb_o = 1'b1;  // user space, always mapped
                end
                SEG_KSEG0: begin
                    addr_o    = {3'b000, addr_i[28:0]};  // strip segment bits
                    illegal_o = user_mode_i;
                end
                SEG_KSEG1: begin
                    addr_o     = {3'b000, addr_i[28:0]};  // same window as kseg0
                    uncached_o = 1'b1;
                    illegal_o  = user_mode_i;
                end
                SEG_KSEG23: begin
                    // kernel mapped
                    using_tlb_o = 1'b1;
                    illegal_o   = user_mode_i;
                end
            endcase
        end
    end

    // uncached flag is still reported on an illegal kseg1 access

endmodule

/* hdl/tlb_lookup.sv */
// combinational fully associative match; on multiple matches the lowest index wins, no detection
`timescale 1ns/1ns

module tlb_lookup import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16  // power of two, 2..64
) (
    input  tlb_entry_t                   entries_i [TLB_ENTRIES],
    input  logic [VPN2_W-1:0]            vpn2_i,   // va[31:13]
    input  logic                         odd_i,    // va[12], selects odd page
    input  logic [ASID_W-1:0]            asid_i,
    output logic                         hit_o,
    output logic [$clog2(TLB_ENTRIES)-1:0] index_o,
    output logic [PFN_W-1:0]             pfn_o,
    output logic                         dirty_o,
    output logic                         valid_o
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [TLB_ENTRIES-1:0] match;  // one bit per slot
    logic [IDX_W-1:0]       sel_idx;
    tlb_entry_t             sel;

    // parallel compare against every slot
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = entries_i[i].vld
                    && (entries_i[i].vpn2 == vpn2_i)
                    && (entries_i[i].g || (entries_i[i].asid == asid_i));
        end
    end

    // priority pick, walk down so the lowest match is left last
    always_comb begin
        sel_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign sel = entries_i[sel_idx];

    // even/odd page select, all zero on miss
    always_comb begin
        hit_o   = |match;
        index_o = '0;
        pfn_o   = '0;
        dirty_o = 1'b0;
        valid_o = 1'b0;

        if (hit_o) begin
            index_o = sel_idx;
            if (odd_i) begin
                pfn_o   = sel.pfn1;
                dirty_o = sel.d1;
                valid_o = sel.v1;
            end else begin
                pfn_o   = sel.pfn0;
                dirty_o = sel.d0;
                valid_o = sel.v0;
            end
        end
    end

    // matching the vld bit means freshly reset slots
    // never hit, even with vpn2 and asid of zero

endmodule

/* hdl/tlb_top.sv */
// tlbwi and tlbp are single-cycle strobes; only vld bits and the probe result are reset
`timescale 1ns/1ns

module tlb_top import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16  // power of two, 2..64
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic [TLB_CFG_W-1:0] tlb_config_i,  // packed entry from cp0
    input  logic                 tlbwi_i,       // write indexed
    input  logic                 tlbp_i,        // probe
    input  logic [ASID_W-1:0]    asid_i,        // current asid
    input  logic [31:0]          data_vaddr_i,
    input  logic [31:0]          inst_vaddr_i,
    output logic [31:0]          data_paddr_o,
    output logic [31:0]          inst_paddr_o,
    output logic                 data_hit_o,
    output logic                 inst_hit_o,
    output logic                 data_dirty_o,
    output logic                 data_valid_o,
    output logic                 inst_valid_o,
    output logic [31:0]          tlbp_result_o
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // config word fields
    logic [CFG_INDEX_W-1:0] cfg_index;
    logic [VPN2_W-1:0]      cfg_vpn2;
    logic [ASID_W-1:0]      cfg_asid;
    logic                   cfg_g;
    logic [PFN_W-1:0]       cfg_pfn0, cfg_pfn1;
    logic                   cfg_d0, cfg_v0, cfg_d1, cfg_v1;
    logic [IDX_W-1:0]       wr_idx;
    tlb_entry_t             wr_entry;

    tlb_entry_t             payload_q [TLB_ENTRIES];  // no reset
    logic [TLB_ENTRIES-1:0] vld_q;
    tlb_entry_t             entries [TLB_ENTRIES];    // what the lookups see

    logic [PFN_W-1:0]       data_pfn, inst_pfn;
    logic                   probe_hit;
    logic [IDX_W-1:0]       probe_idx;
    logic [31:0]            probe_d, probe_q;

    assign cfg_index = tlb_config_i[CFG_INDEX_HI:CFG_INDEX_LO];
    assign cfg_vpn2  = tlb_config_i[CFG_VPN2_HI:CFG_VPN2_LO];
    assign cfg_asid  = tlb_config_i[CFG_ASID_HI:CFG_ASID_LO];
    assign cfg_g     = tlb_config_i[CFG_G];
    assign cfg_pfn0  = tlb_config_i[CFG_PFN0_HI:CFG_PFN0_LO];
    assign cfg_d0    = tlb_config_i[CFG_D0];
    assign cfg_v0    = tlb_config_i[CFG_V0];
    assign cfg_pfn1  = tlb_config_i[CFG_PFN1_HI:CFG_PFN1_LO];
    assign cfg_d1    = tlb_config_i[CFG_D1];
    assign cfg_v1    = tlb_config_i[CFG_V1];
    assign wr_idx    = cfg_index[IDX_W-1:0];  // upper index bits ignored

    assign wr_entry = '{vpn2: cfg_vpn2, asid: cfg_asid, g: cfg_g,
                        pfn0: cfg_pfn0, d0: cfg_d0, v0: cfg_v0,
                        pfn1: cfg_pfn1, d1: cfg_d1, v1: cfg_v1,
                        vld: 1'b1};

    // slot valid bits, cleared on reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else if (tlbwi_i) begin
            vld_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbwi_i) payload_q[wr_idx] <= wr_entry;
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            entries[i]     = payload_q[i];
            entries[i].vld = vld_q[i];  // reset state overrides stale payload
        end
    end

    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) lookup_data (
        .entries_i (entries),
        .vpn2_i    (data_vaddr_i[31:13]),
        .odd_i     (data_vaddr_i[12]),
        .asid_i    (asid_i),
        .hit_o     (data_hit_o),
        .index_o   (),
        .pfn_o     (data_pfn),
        .dirty_o   (data_dirty_o),
        .valid_o   (data_valid_o)
    );

    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) lookup_inst (
        .entries_i (entries),
        .vpn2_i    (inst_vaddr_i[31:13]),
        .odd_i     (inst_vaddr_i[12]),
        .asid_i    (asid_i),
        .hit_o     (inst_hit_o),
        .index_o   (),
        .pfn_o     (inst_pfn),
        .dirty_o   (),          // fetches never write
        .valid_o   (inst_valid_o)
    );

    // probe key is config vpn2 with the live asid
    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) lookup_probe (
        .entries_i (entries),
        .vpn2_i    (cfg_vpn2),
        .odd_i     (1'b0),
        .asid_i    (asid_i),
        .hit_o     (probe_hit),
        .index_o   (probe_idx),
        .pfn_o     (),
        .dirty_o   (),
        .valid_o   ()
    );

    assign data_paddr_o = {data_pfn, data_vaddr_i[OFFSET_W-1:0]};  // pfn | page offset
    assign inst_paddr_o = {inst_pfn, inst_vaddr_i[OFFSET_W-1:0]};

    assign probe_d = probe_hit ? 32'(probe_idx) : (32'd1 << PROBE_MISS_BIT);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            probe_q <= '0;
        end else if (tlbp_i) begin
            probe_q <= probe_d;  // held until next probe
        end
    end

    assign tlbp_result_o = probe_q;

endmodule

/* hdl/mmu_top.sv */
// translations are combinational levels; caller holds the address while it needs the result
`timescale 1ns/1ns

module mmu_top import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16  // power of two, 2..64
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic [31:0]          data_addr_i,    // virtual, data channel
    input  logic [31:0]          inst_addr_i,    // virtual, fetch channel
    input  logic                 data_enable_i,
    input  logic                 inst_enable_i,
    input  logic                 data_write_i,   // store, qualifies dirty
    input  logic                 user_mode_i,
    input  logic [TLB_CFG_W-1:0] tlb_config_i,
    input  logic                 tlbwi_i,
    input  logic                 tlbp_i,
    input  logic [ASID_W-1:0]    asid_i,
    output logic [31:0]          data_addr_o,    // physical
    output logic [31:0]          inst_addr_o,
    output logic [31:0]          tlbp_result_o,
    output logic                 data_uncached_o,
    output logic                 inst_uncached_o,
    output logic                 data_exp_miss_o,
    output logic                 inst_exp_miss_o,
    output logic                 data_exp_illegal_o,
    output logic                 inst_exp_illegal_o,
    output logic                 data_exp_invalid_o,
    output logic                 inst_exp_invalid_o,
    output logic                 data_exp_dirty_o
);

    logic [31:0] data_addr_direct, inst_addr_direct;
    logic [31:0] data_addr_tlb, inst_addr_tlb;
    logic        data_using_tlb, inst_using_tlb;  // already gated by enable
    logic        data_hit, inst_hit;
    logic        data_dirty, data_valid, inst_valid;
    logic        data_mapped, inst_mapped;

    mem_map mem_map_data (
        .addr_i      (data_addr_i),
        .enable_i    (data_enable_i),
        .user_mode_i (user_mode_i),
        .addr_o      (data_addr_direct),
        .using_tlb_o (data_using_tlb),
        .illegal_o   (data_exp_illegal_o),
        .uncached_o  (data_uncached_o)
    );

    mem_map mem_map_inst (
        .addr_i      (inst_addr_i),
        .enable_i    (inst_enable_i),
        .user_mode_i (user_mode_i),
        .addr_o      (inst_addr_direct),
        .using_tlb_o (inst_using_tlb),
        .illegal_o   (inst_exp_illegal_o),
        .uncached_o  (inst_uncached_o)
    );

    tlb_top #(.TLB_ENTRIES(TLB_ENTRIES)) tlb (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .tlb_config_i  (tlb_config_i),
        .tlbwi_i       (tlbwi_i),
        .tlbp_i        (tlbp_i),
        .asid_i        (asid_i),
        .data_vaddr_i  (data_addr_i),
        .inst_vaddr_i  (inst_addr_i),
        .data_paddr_o  (data_addr_tlb),
        .inst_paddr_o  (inst_addr_tlb),
        .data_hit_o    (data_hit),
        .inst_hit_o    (inst_hit),
        .data_dirty_o  (data_dirty),
        .data_valid_o  (data_valid),
        .inst_valid_o  (inst_valid),
        .tlbp_result_o (tlbp_result_o)
    );

    // disabled channel gives direct path, which is zero then
    assign data_addr_o = data_using_tlb ? data_addr_tlb : data_addr_direct;
    assign inst_addr_o = inst_using_tlb ? inst_addr_tlb : inst_addr_direct;

    // illegal access masks all tlb exceptions
    assign data_mapped = data_using_tlb & ~data_exp_illegal_o;
    assign inst_mapped = inst_using_tlb & ~inst_exp_illegal_o;

    assign data_exp_miss_o    = data_mapped & ~data_hit;
    assign inst_exp_miss_o    = inst_mapped & ~inst_hit;
    assign data_exp_invalid_o = data_mapped & data_hit & ~data_valid;
    assign inst_exp_invalid_o = inst_mapped & inst_hit & ~inst_valid;

    // store to a clean but valid page
    assign data_exp_dirty_o = data_mapped & data_hit & data_valid & ~data_dirty & data_write_i;

endmodule

/* verification/mmu_tb.sv */
// table-driven check of mmu_top with 16 tlb entries; probe results are sampled one cycle late
`timescale 1ns/1ns

module mmu_tb import mmu_pkg::*; ();

    typedef enum logic [1:0] {OP_WRITE, OP_PROBE, OP_XLATE} op_e;

    // expected flags {uncached, illegal, miss, invalid, dirty}
    localparam logic [4:0] F_NONE = 5'b00000, F_UNC = 5'b10000, F_ILL = 5'b01000;
    localparam logic [4:0] F_MISS = 5'b00100, F_INV = 5'b00010, F_DIRTY = 5'b00001;
    localparam logic [18:0] VPN_A = 19'h00123;  // kuseg pair
    localparam logic [18:0] VPN_B = 19'h60000;  // kseg2, global
    localparam logic [18:0] VPN_C = 19'h00400;  // replaces A at index 3
    localparam logic [31:0] MISS_RES = 32'h8000_0000;

    typedef struct packed {
        op_e                  op;
        logic [TLB_CFG_W-1:0] cfg;
        logic [31:0]          daddr, iaddr;
        logic                 den, ien, user, wr;
        logic [7:0]           asid;
        logic [31:0]          exp_daddr, exp_iaddr;
        logic                 chk_daddr, chk_iaddr;  // address defined only on direct or hit
        logic [4:0]           exp_df, exp_if;
        logic [31:0]          exp_probe;
    } row_t;

    logic clk = 1'b0, arst_n_i = 1'b0;
    logic [31:0] data_addr_i = '0, inst_addr_i = '0;
    logic data_enable_i = 1'b0, inst_enable_i = 1'b0, data_write_i = 1'b0, user_mode_i = 1'b0;
    logic [TLB_CFG_W-1:0] tlb_config_i = '0;
    logic tlbwi_i = 1'b0, tlbp_i = 1'b0;
    logic [7:0] asid_i = '0;
    logic [31:0] data_addr_o, inst_addr_o, tlbp_result_o;
    logic data_uncached_o, inst_uncached_o, data_exp_miss_o, inst_exp_miss_o;
    logic data_exp_illegal_o, inst_exp_illegal_o, data_exp_invalid_o, inst_exp_invalid_o;
    logic data_exp_dirty_o;

    row_t rows[$];
    int   seed = 32'h945f;
    int   checks = 0, errors = 0, cycles = 0, limit = 1000;

    mmu_top #(.TLB_ENTRIES(16)) uut (.*);

    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run went past %0d cycles without finishing", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // c fields set to 3 to show they are ignored
    function automatic logic [TLB_CFG_W-1:0] make_cfg(input logic [5:0] idx,
            input logic [18:0] vpn2, input logic [7:0] asid, input logic g,
            input logic [19:0] pfn0, input logic d0, input logic v0,
            input logic [19:0] pfn1, input logic d1, input logic v1);
        return {idx, vpn2, asid, g, pfn0, 3'd3, d0, v0, pfn1, 3'd3, d1, v1};
    endfunction

    task automatic add_write(input logic [5:0] idx, input logic [18:0] vpn2,
            input logic [7:0] asid, input logic g, input logic [19:0] pfn0,
            input logic d0, input logic v0, input logic [19:0] pfn1, input logic d1,
            input logic v1);
        row_t r;
        r = '0;
        r.op  = OP_WRITE;
        r.cfg = make_cfg(idx, vpn2, asid, g, pfn0, d0, v0, pfn1, d1, v1);
        rows.push_back(r);
    endtask

    task automatic add_probe(input logic [18:0] vpn2, input logic [7:0] asid,
            input logic [31:0] exp);
        row_t r;
        r = '0;
        r.op        = OP_PROBE;
        r.cfg       = make_cfg(6'd0, vpn2, 8'h00, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        r.asid      = asid;  // probe key uses live asid
        r.exp_probe = exp;
        rows.push_back(r);
    endtask

    task automatic add_xlate(input logic [31:0] da, input logic [31:0] ia, input logic den,
            input logic ien, input logic user, input logic wr, input logic [7:0] asid,
            input logic [31:0] exp_da, input logic chk_d, input logic [31:0] exp_ia,
            input logic chk_i, input logic [4:0] df, input logic [4:0] fi);
        row_t r;
        r = '0;
        r.op = OP_XLATE;
        r.daddr = da;
        r.iaddr = ia;
        {r.den, r.ien, r.user, r.wr, r.asid} = {den, ien, user, wr, asid};
        {r.exp_daddr, r.chk_daddr, r.exp_iaddr, r.chk_iaddr} = {exp_da, chk_d, exp_ia, chk_i};
        {r.exp_df, r.exp_if} = {df, fi};
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [11:0] od, oi;
        logic [31:0] k0, k1, k2;
        od = 12'(rnd());
        oi = 12'(rnd());
        k0 = 32'h8000_0000 | (rnd() >> 3);  // kseg0, random low bits
        k1 = 32'ha000_0000 | (rnd() >> 3);
        k2 = 32'hc000_0000 | (rnd() >> 3);
        // after reset nothing maps
        add_xlate({VPN_A, 1'b0, od}, {VPN_A, 1'b1, oi}, 1, 1, 0, 0, 8'h11, '0, 0, '0, 0,
                  F_MISS, F_MISS);
        add_probe(VPN_A, 8'h11, MISS_RES);
        // direct segments clear the top three bits
        add_xlate(k0, k1, 1, 1, 0, 0, 8'h00, k0 & 32'h1fff_ffff, 1, k1 & 32'h1fff_ffff, 1,
                  F_NONE, F_UNC);
        add_xlate(k1, k0, 1, 1, 0, 1, 8'h00, k1 & 32'h1fff_ffff, 1, k0 & 32'h1fff_ffff, 1,
                  F_UNC, F_NONE);
        // kernel segments from user mode
        add_xlate(k0, k2, 1, 1, 1, 1, 8'h11, k0 & 32'h1fff_ffff, 1, '0, 0, F_ILL, F_ILL);
        add_xlate(k1, k0, 1, 1, 1, 0, 8'h11, k1 & 32'h1fff_ffff, 1, k0 & 32'h1fff_ffff, 1,
                  F_ILL | F_UNC, F_ILL);
        add_xlate({VPN_A, 1'b0, od}, k1, 0, 0, 1, 1, 8'h11, '0, 1, '0, 1, F_NONE, F_NONE);
        // pair A at index 3, odd page clean
        add_write(6'd3, VPN_A, 8'h11, 0, 20'habcd, 1, 1, 20'h01234, 0, 1);
        add_xlate({VPN_A, 1'b0, od}, {VPN_A, 1'b1, oi}, 1, 1, 1, 0, 8'h11,
                  {20'habcd, od}, 1, {20'h01234, oi}, 1, F_NONE, F_NONE);
        add_xlate({VPN_A, 1'b0, od}, {VPN_A, 1'b1, oi}, 1, 1, 1, 0, 8'h22, '0, 0, '0, 0,
                  F_MISS, F_MISS);
        // global pair B at index 5, even page invalid
        add_write(6'd5, VPN_B, 8'h33, 1, 20'h45678, 1, 0, 20'h99999, 1, 1);
        add_xlate({VPN_B, 1'b0, od}, {VPN_B, 1'b1, oi}, 1, 1, 0, 0, 8'h77,
                  {20'h45678, od}, 1, {20'h99999, oi}, 1, F_INV, F_NONE);
        // dirty only on a data store to a clean page
        add_xlate({VPN_A, 1'b1, od}, {VPN_A, 1'b1, oi}, 1, 1, 1, 1, 8'h11,
                  {20'h01234, od}, 1, {20'h01234, oi}, 1, F_DIRTY, F_NONE);
        add_xlate({VPN_A, 1'b1, od}, {VPN_A, 1'b1, oi}, 1, 1, 1, 0, 8'h11,
                  {20'h01234, od}, 1, {20'h01234, oi}, 1, F_NONE, F_NONE);
        add_xlate({VPN_B, 1'b1, od}, {VPN_B, 1'b0, oi}, 1, 1, 0, 1, 8'h77,
                  {20'h99999, od}, 1, {20'h45678, oi}, 1, F_NONE, F_INV);
        // probes, then index 3 rewritten
        add_probe(VPN_A, 8'h11, 32'd3);
        add_probe(VPN_B, 8'h99, 32'd5);
        add_probe(VPN_A, 8'h22, MISS_RES);
        add_write(6'd3, VPN_C, 8'h11, 0, 20'h77777, 1, 1, 20'h88888, 1, 1);
        add_xlate({VPN_A, 1'b0, od}, {VPN_C, 1'b1, oi}, 1, 1, 1, 0, 8'h11,
                  '0, 0, {20'h88888, oi}, 1, F_MISS, F_NONE);
        add_probe(VPN_A, 8'h11, MISS_RES);
        add_probe(VPN_C, 8'h11, 32'd3);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %0b got %0b", $time, name, exp, act);
        end
    endtask

    task automatic apply_row(input int n, input row_t r);
        int errs_before;
        errs_before = errors;
        @(posedge clk);
        #5;
        {data_addr_i, inst_addr_i, tlb_config_i, asid_i} = {r.daddr, r.iaddr, r.cfg, r.asid};
        {data_enable_i, inst_enable_i, user_mode_i, data_write_i} = {r.den, r.ien, r.user, r.wr};
        tlbwi_i = (r.op == OP_WRITE);
        tlbp_i  = (r.op == OP_PROBE);
        if (r.op == OP_XLATE) begin
            #40;  // combinational, settled well before the next edge
            if (r.chk_daddr) check_word("data_addr_o", r.exp_daddr, data_addr_o);
            if (r.chk_iaddr) check_word("inst_addr_o", r.exp_iaddr, inst_addr_o);
            check_bit("data_uncached_o", r.exp_df[4], data_uncached_o);
            check_bit("data_exp_illegal_o", r.exp_df[3], data_exp_illegal_o);
            check_bit("data_exp_miss_o", r.exp_df[2], data_exp_miss_o);
            check_bit("data_exp_invalid_o", r.exp_df[1], data_exp_invalid_o);
            check_bit("data_exp_dirty_o", r.exp_df[0], data_exp_dirty_o);
            check_bit("inst_uncached_o", r.exp_if[4], inst_uncached_o);
            check_bit("inst_exp_illegal_o", r.exp_if[3], inst_exp_illegal_o);
            check_bit("inst_exp_miss_o", r.exp_if[2], inst_exp_miss_o);
            check_bit("inst_exp_invalid_o", r.exp_if[1], inst_exp_invalid_o);
        end else begin
            @(posedge clk);
            #5;
            tlbwi_i = 1'b0;
            tlbp_i  = 1'b0;
            if (r.op == OP_PROBE) check_word("tlbp_result_o", r.exp_probe, tlbp_result_o);
        end
        $display("row %0d %s: %s", n, r.op.name(), (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        build_table();
        limit = 16 + 3 * rows.size() + 50;
        repeat (16) @(posedge clk);
        #5 arst_n_i = 1'b1;
        foreach (rows[i]) apply_row(i, rows[i]);
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/mmu_pkg.sv
hdl/mem_map.sv
hdl/tlb_lookup.sv
hdl/tlb_top.sv
hdl/mmu_top.sv
verification/mmu_tb.sv

/* Makefile */
# Verilator build and run for the MMU testbench

VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -qx "TESTS PASSED" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
